// ==== src.f ====
motor_pkg.sv
spi_target.sv
command_decoder.sv
phase_driver.sv
quad_encoder.sv
motor_core.sv
tb_clock.sv
motor_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module motor_core_tb

# Pass or fail is taken from the simulation output
out=$(./obj_dir/Vmotor_core_tb 2>&1) || true
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'

// ==== motor_core_tb.sv ====
`timescale 1ns/1ps

module motor_core_tb import motor_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int N_STEPS      = 24;
  localparam int N_MOVES      = 48;
  localparam int FRAME_CYCLES = 10 + 5 * 8 * 10 + 15;  // Longest frame plus gaps
  localparam int N_FRAMES     = 8 + N_STEPS + N_STEPS / 8 + N_MOVES / 16;
  localparam int RUN_CYCLES   = N_FRAMES * FRAME_CYCLES + 2 * 256 + 3 * N_MOVES * 5;
  localparam int WATCHDOG_NS  = 20 * RUN_CYCLES * CLK_PERIOD;

  logic       CLK;
  logic       resetn;
  logic       sck, cs, copi, cipo;
  logic       step_in, dir_in;
  logic       enc_a, enc_b;
  phase_out_t phase;
  logic       vref_a, vref_b;

  logic [7:0]  tx_buf [0:4];
  logic [7:0]  rx_buf [0:4];
  logic [15:0] lfsr;

  // Reference model state
  logic [1:0]  m_idx;
  logic [7:0]  m_cur;
  logic        m_en, m_rev, m_fault;
  int          m_count;
  logic [1:0]  enc_pos;  // Position in the Gray sequence

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) tb_clock_i (.CLK, .resetn);

  motor_core #(.SYNC_STAGES(2)) motor_core_i (
    .CLK, .resetn, .sck, .cs, .copi, .cipo, .step_in, .dir_in,
    .enc_a, .enc_b, .phase, .vref_a, .vref_b
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [3:0] phase_for(input logic [1:0] idx, input logic en);
    if (!en) return 4'b0000;
    case (idx)
      2'd0: return 4'b1010;
      2'd1: return 4'b0110;
      2'd2: return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  function automatic logic [1:0] enc_code(input logic [1:0] p);
    case (p)
      2'd0: return 2'b00;
      2'd1: return 2'b10;
      2'd2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "check failed");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // Mode 0, 10 clocks per bit, CIPO sampled as SCK rises
  task automatic spi_frame(input int nbytes);
    logic [7:0] rx;
    cs = 1'b0;
    wait_cycles(10);
    for (int i = 0; i < nbytes; i++) begin
      for (int b = 7; b >= 0; b--) begin
        copi = tx_buf[i][b];
        wait_cycles(5);
        rx[b] = cipo;
        sck = 1'b1;
        wait_cycles(5);
        sck = 1'b0;
      end
      rx_buf[i] = rx;
    end
    wait_cycles(5);
    cs   = 1'b1;
    copi = 1'b0;
    wait_cycles(10);
  endtask

  task automatic frame_with_status(input int nbytes);
    spi_frame(nbytes);
    check("status", rx_buf[0], {4'h0, m_idx, m_en, m_fault});
    m_fault = 1'b0;  // Cleared when the frame starts
  endtask

  task automatic write_config(input logic [7:0] cur, input logic en, input logic rev);
    tx_buf[0] = OP_WRITE_CONFIG;
    tx_buf[1] = cur;
    tx_buf[2] = {6'b0, rev, en};
    frame_with_status(3);
    m_cur = cur;
    m_en  = en;
    m_rev = rev;
  endtask

  task automatic read_encoder();
    tx_buf[0] = OP_READ_ENCODER;
    for (int i = 1; i < 5; i++) tx_buf[i] = 8'h00;
    frame_with_status(5);
    check("count", {rx_buf[1], rx_buf[2], rx_buf[3], rx_buf[4]}, m_count);
  endtask

  // Moving A ahead of B counts up
  task automatic enc_move(input logic up);
    enc_pos = up ? enc_pos + 2'd1 : enc_pos - 2'd1;
    {enc_a, enc_b} = enc_code(enc_pos);
    m_count = up ? m_count + 1 : m_count - 1;
    wait_cycles(5);
  endtask

  task automatic step_once(input logic dir, input logic use_pin);
    if (use_pin) begin
      dir_in = dir;
      wait_cycles(1);
      step_in = 1'b1;
      wait_cycles(4);
      step_in = 1'b0;
      wait_cycles(4);
    end else begin
      tx_buf[0] = OP_STEP;
      tx_buf[1] = {7'b0, dir};
      frame_with_status(2);
    end
    m_idx = (dir ^ m_rev) ? m_idx + 2'd1 : m_idx - 2'd1;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the test did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    int          high_a;
    int          high_b;
    sck     = 1'b0;
    cs      = 1'b1;
    copi    = 1'b0;
    step_in = 1'b0;
    dir_in  = 1'b0;
    enc_a   = 1'b0;
    enc_b   = 1'b0;
    lfsr    = 16'h0001;
    m_idx   = '0;
    m_cur   = '0;
    m_en    = 1'b0;
    m_rev   = 1'b0;
    m_fault = 1'b0;
    m_count = 0;
    enc_pos = '0;
    @(posedge resetn);
    wait_cycles(1);

    check("phase", phase, 4'h0);
    check("vref_a", vref_a, 1'b0);
    check("vref_b", vref_b, 1'b0);
    check("cipo", cipo, 1'b0);
    read_encoder();

    // PWM duty over one full counter period
    rand_bits(8, r);
    write_config(r[7:0] | 8'h80, 1'b1, 1'b0);  // Duty in the upper half of the scale
    wait_cycles(2);
    high_a = 0;
    high_b = 0;
    repeat (256) begin
      if (vref_a) high_a++;
      if (vref_b) high_b++;
      wait_cycles(1);
    end
    check("vref_a high cycles", high_a, m_cur);
    check("vref_b high cycles", high_b, m_cur);
    write_config(m_cur, 1'b0, 1'b0);
    repeat (256) begin
      check("phase", phase, 4'h0);
      check("vref_a", vref_a, 1'b0);
      check("vref_b", vref_b, 1'b0);
      wait_cycles(1);
    end

    for (int i = 0; i < N_STEPS; i++) begin
      if (i % 8 == 0) begin
        rand_bits(1, r);
        write_config(m_cur, 1'b1, r[0]);  // New reverse setting
      end
      rand_bits(2, r);
      step_once(r[0], r[1]);
      check("phase", phase, phase_for(m_idx, m_en));
    end

    for (int i = 0; i < N_MOVES; i++) begin
      rand_bits(1, r);
      enc_move(r[0]);
      if (i % 16 == 15) read_encoder();
    end
    while (m_count > -4) enc_move(1'b0);  // Make sure a negative count is read
    read_encoder();

    // Both inputs flip together
    {enc_a, enc_b} = ~{enc_a, enc_b};
    enc_pos = enc_pos + 2'd2;
    m_fault = 1'b1;
    wait_cycles(5);
    read_encoder();
    read_encoder();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Released just after an edge, like the other inputs
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 resetn = 1'b1;
  end

endmodule

// ==== motor_core.sv ====
`timescale 1ns/1ps

module motor_core import motor_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  output logic       cipo,
  input  logic       step_in,
  input  logic       dir_in,
  input  logic       enc_a,
  input  logic       enc_b,
  output phase_out_t phase,
  output logic       vref_a,
  output logic       vref_b
);

  logic                          frame_start;
  logic                          rx_valid;
  logic [7:0]                    rx_byte;
  logic [7:0]                    tx_byte;
  drive_cfg_t                    cfg;
  step_cmd_t                     spi_step;
  logic [1:0]                    phase_index;
  logic signed [COUNT_WIDTH-1:0] count;
  logic                          fault;
  logic                          fault_clear;

  spi_target #(.SYNC_STAGES(SYNC_STAGES)) spi_target_i (
    .CLK, .resetn, .sck, .cs, .copi, .cipo,
    .frame_start, .rx_valid, .rx_byte, .tx_byte
  );

  command_decoder command_decoder_i (
    .CLK, .resetn, .frame_start, .rx_valid, .rx_byte, .tx_byte,
    .cfg, .spi_step, .phase_index, .count, .fault, .fault_clear
  );

  // Step events from SPI and the STEP/DIR pins
  phase_driver #(.SYNC_STAGES(SYNC_STAGES)) phase_driver_i (
    .CLK, .resetn, .cfg, .spi_step, .step_in, .dir_in,
    .phase, .phase_index, .vref_a, .vref_b
  );

  quad_encoder #(.SYNC_STAGES(SYNC_STAGES)) quad_encoder_i (
    .CLK, .resetn, .enc_a, .enc_b, .fault_clear, .count, .fault
  );

endmodule

// ==== quad_encoder.sv ====
`timescale 1ns/1ps

module quad_encoder import motor_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                          CLK,
  input  logic                          resetn,
  input  logic                          enc_a,
  input  logic                          enc_b,
  input  logic                          fault_clear,
  output logic signed [COUNT_WIDTH-1:0] count,
  output logic                          fault
);

  logic [SYNC_STAGES-1:0][1:0] enc_sync;  // {a, b} per stage
  logic       a_s, b_s;
  logic [1:0] ab_q;
  logic [1:0] pos_new;
  logic [1:0] pos_old;
  logic [1:0] delta;

  assign {a_s, b_s} = enc_sync[SYNC_STAGES-1];

  // Gray code to position, 00 10 11 01 maps to 0 1 2 3
  assign pos_new = {b_s, a_s ^ b_s};
  assign pos_old = {ab_q[0], ab_q[1] ^ ab_q[0]};
  assign delta   = pos_new - pos_old;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_sync <= '0;
      ab_q     <= '0;
    end else begin
      enc_sync <= {enc_sync[SYNC_STAGES-2:0], {enc_a, enc_b}};
      ab_q     <= {a_s, b_s};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
    end else begin
      case (delta)
        2'd1: count <= count + 1;  // A leads B
        2'd3: count <= count - 1;
        default: ;
      endcase
      // New fault wins over a clear in the same cycle
      if (delta == 2'd2) begin
        fault <= 1'b1;
      end else if (fault_clear) begin
        fault <= 1'b0;
      end
    end
  end

endmodule

// ==== phase_driver.sv ====
`timescale 1ns/1ps

module phase_driver import motor_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       CLK,
  input  logic       resetn,
  input  drive_cfg_t cfg,
  input  step_cmd_t  spi_step,
  input  logic       step_in,
  input  logic       dir_in,
  output phase_out_t phase,
  output logic [1:0] phase_index,
  output logic       vref_a,
  output logic       vref_b
);

  logic [SYNC_STAGES-1:0][1:0] pin_sync;  // {step, dir} per stage
  logic       step_s, dir_s;
  logic       step_d;
  logic       pin_step;
  logic       step_go;
  logic       step_dir;
  logic [7:0] pwm_cnt;
  logic       vref_on;

  assign {step_s, dir_s} = pin_sync[SYNC_STAGES-1];
  assign pin_step = step_s & ~step_d;

  // Pin step has priority over an SPI step
  always_comb begin
    if (pin_step) begin
      step_go  = 1'b1;
      step_dir = dir_s;
    end else begin
      step_go  = spi_step.strobe;
      step_dir = spi_step.dir;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pin_sync    <= '0;
      step_d      <= 1'b0;
      phase_index <= '0;
    end else begin
      pin_sync <= {pin_sync[SYNC_STAGES-2:0], {step_in, dir_in}};
      step_d   <= step_s;
      if (step_go) begin
        phase_index <= (step_dir ^ cfg.reverse) ? phase_index + 2'd1 : phase_index - 2'd1;
      end
    end
  end

  // Full-step table, index keeps moving while disabled
  always_comb begin
    case (phase_index)
      2'd0: phase = 4'b1010;  // A+ B+
      2'd1: phase = 4'b0110;  // A- B+
      2'd2: phase = 4'b0101;  // A- B-
      default: phase = 4'b1001;  // A+ B-
    endcase
    if (!cfg.enable) phase = '0;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pwm_cnt <= '0;
      vref_on <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 8'd1;  // Wraps every 256 cycles
      vref_on <= cfg.enable && (pwm_cnt < cfg.current);
    end
  end

  assign vref_a = vref_on;
  assign vref_b = vref_on;

endmodule

// ==== command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder import motor_pkg::*; (
  input  logic                          CLK,
  input  logic                          resetn,
  input  logic                          frame_start,
  input  logic                          rx_valid,
  input  logic [7:0]                    rx_byte,
  output logic [7:0]                    tx_byte,
  output drive_cfg_t                    cfg,
  output step_cmd_t                     spi_step,
  input  logic [1:0]                    phase_index,
  input  logic signed [COUNT_WIDTH-1:0] count,
  input  logic                          fault,
  output logic                          fault_clear
);

  logic [2:0]             byte_pos;  // Saturates at 7
  spi_op_e                opcode;
  spi_op_e                op_now;
  logic [7:0]             cur_hold;
  logic [COUNT_WIDTH-1:0] count_snap;
  status_t                status;

  always_comb begin
    status             = '0;
    status.fault       = fault;
    status.enable      = cfg.enable;
    status.phase_index = phase_index;
  end

  // Opcode byte acts on itself before it is stored
  assign op_now = (byte_pos == 3'd0) ? spi_op_e'(rx_byte) : opcode;

  assign fault_clear = frame_start;  // Status is latched on this same edge

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      byte_pos <= '0;
      opcode   <= spi_op_e'(8'h00);
      cfg      <= '0;
      spi_step <= '0;
      tx_byte  <= '0;
    end else begin
      spi_step.strobe <= 1'b0;
      if (frame_start) begin
        byte_pos <= '0;
        tx_byte  <= status;
      end else if (rx_valid) begin
        if (byte_pos != 3'd7) byte_pos <= byte_pos + 3'd1;
        if (byte_pos == 3'd0) opcode <= op_now;
        tx_byte <= '0;
        case (op_now)
          OP_WRITE_CONFIG: begin
            if (byte_pos == 3'd2) begin
              cfg <= '{current: cur_hold, enable: rx_byte[0], reverse: rx_byte[1]};
            end
          end
          OP_STEP: begin
            if (byte_pos == 3'd1) spi_step <= '{strobe: 1'b1, dir: rx_byte[0]};
          end
          OP_READ_ENCODER: begin
            case (byte_pos)
              3'd0: tx_byte <= count[31:24];  // Snapshot is taken this same edge
              3'd1: tx_byte <= count_snap[23:16];
              3'd2: tx_byte <= count_snap[15:8];
              3'd3: tx_byte <= count_snap[7:0];
              default: tx_byte <= '0;
            endcase
          end
          default: ;  // Unknown opcode, rest of frame ignored
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_valid && byte_pos == 3'd1) cur_hold <= rx_byte;
    if (rx_valid && byte_pos == 3'd0 && op_now == OP_READ_ENCODER) count_snap <= count;
  end

endmodule

// ==== spi_target.sv ====
`timescale 1ns/1ps

module spi_target #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  output logic       cipo,
  output logic       frame_start,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  input  logic [7:0] tx_byte
);

  logic [SYNC_STAGES-1:0][2:0] pin_sync;  // {sck, cs, copi} per stage
  logic sck_s, cs_s, copi_s;
  logic sck_d, cs_d;
  logic sck_rise, sck_fall, cs_fall;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic load_pending;  // Next byte waits for the falling edge
  logic first_load;

  assign {sck_s, cs_s, copi_s} = pin_sync[SYNC_STAGES-1];

  assign sck_rise = sck_s & ~sck_d;
  assign sck_fall = ~sck_s & sck_d;
  assign cs_fall  = ~cs_s & cs_d;

  assign cipo = tx_shift[7];  // MSB first

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pin_sync <= {SYNC_STAGES{3'b010}};  // cs idles high
      sck_d    <= 1'b0;
      cs_d     <= 1'b1;
    end else begin
      pin_sync <= {pin_sync[SYNC_STAGES-2:0], {sck, cs, copi}};
      sck_d    <= sck_s;
      cs_d     <= cs_s;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      frame_start  <= 1'b0;
      rx_valid     <= 1'b0;
      first_load   <= 1'b0;
      bit_cnt      <= '0;
      tx_shift     <= '0;
      load_pending <= 1'b0;
    end else begin
      frame_start <= cs_fall;
      first_load  <= frame_start;  // Status byte is ready by now
      rx_valid    <= 1'b0;
      if (cs_s) begin
        // Deselected, any partial byte is dropped
        bit_cnt      <= '0;
        load_pending <= 1'b0;
        tx_shift     <= '0;
      end else begin
        if (first_load) begin
          tx_shift <= tx_byte;
        end else if (sck_fall) begin
          tx_shift     <= load_pending ? tx_byte : {tx_shift[6:0], 1'b0};
          load_pending <= 1'b0;
        end
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            rx_valid     <= 1'b1;
            load_pending <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_s) begin
      rx_shift <= {rx_shift[5:0], copi_s};
      if (bit_cnt == 3'd7) rx_byte <= {rx_shift, copi_s};
    end
  end

endmodule

// ==== motor_pkg.sv ====
package motor_pkg;

  // Read reply is four bytes, so the count width is fixed
  localparam int COUNT_WIDTH = 32;

  // Opcode carried in byte 0 of every frame
  typedef enum logic [7:0] {
    OP_WRITE_CONFIG = 8'h10,
    OP_STEP         = 8'h20,
    OP_READ_ENCODER = 8'h30
  } spi_op_e;

  // Drive configuration held by the decoder
  typedef struct packed {
    logic [7:0] current;  // PWM duty out of 256
    logic       enable;
    logic       reverse;  // Inverts every step direction
  } drive_cfg_t;

  typedef struct packed {
    logic strobe;
    logic dir;  // 1 moves the index up
  } step_cmd_t;

  // H-bridge drive pattern
  typedef struct packed {
    logic a1;
    logic a2;
    logic b1;
    logic b2;
  } phase_out_t;

  // Reply in byte 0 of each frame
  typedef struct packed {
    logic [3:0] rsvd;
    logic [1:0] phase_index;
    logic       enable;
    logic       fault;
  } status_t;

endpackage
